//--- build.f
hdl/mips_pkg.sv
hdl/ctrl.sv
hdl/rf.sv
hdl/alu.sv
hdl/hazard_unit.sv
hdl/dm.sv
hdl/mips.sv
tests/tb_mips.sv

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
  input  mips_pkg::word_t   a,
  input  mips_pkg::word_t   b,
  input  mips_pkg::alu_op_t op,
  output mips_pkg::word_t   y
);

  always_comb begin
    case (op)
      mips_pkg::alu_add: y = a + b;
      mips_pkg::alu_sub: y = a - b;
      mips_pkg::alu_and: y = a & b;
      mips_pkg::alu_or:  y = a | b;
      // signed compare
      mips_pkg::alu_slt: y = {31'b0, $signed(a) < $signed(b)};
      // shift amount sits in a
      mips_pkg::alu_sll: y = b << a[4:0];
      mips_pkg::alu_lui: y = {b[15:0], 16'b0};
      default:           y = '0;
    endcase
  end

endmodule

//--- hdl/ctrl.sv
`timescale 1ns/1ps

module ctrl (
  input  mips_pkg::instr_t instr,
  output mips_pkg::ctrl_t  ctrl
);

  always_comb begin
    // anything not decoded below stays all zero and acts as a nop
    ctrl = '0;
    case (instr.r.op)
      mips_pkg::op_rtype: begin
        ctrl.reg_dst = 1'b1;
        case (instr.r.funct)
          mips_pkg::fn_addu: begin
            ctrl.reg_wr = 1'b1;
            ctrl.alu_op = mips_pkg::alu_add;
          end
          mips_pkg::fn_subu: begin
            ctrl.reg_wr = 1'b1;
            ctrl.alu_op = mips_pkg::alu_sub;
          end
          mips_pkg::fn_and: begin
            ctrl.reg_wr = 1'b1;
            ctrl.alu_op = mips_pkg::alu_and;
          end
          mips_pkg::fn_or: begin
            ctrl.reg_wr = 1'b1;
            ctrl.alu_op = mips_pkg::alu_or;
          end
          mips_pkg::fn_slt: begin
            ctrl.reg_wr = 1'b1;
            ctrl.alu_op = mips_pkg::alu_slt;
          end
          mips_pkg::fn_sll: begin
            ctrl.reg_wr = 1'b1;
            ctrl.alu_op = mips_pkg::alu_sll;
          end
          default: ctrl = '0;
        endcase
      end
      mips_pkg::op_addiu: begin
        ctrl.reg_wr     = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.ext_signed = 1'b1;
        ctrl.alu_op     = mips_pkg::alu_add;
      end
      mips_pkg::op_ori: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.alu_op  = mips_pkg::alu_or;
      end
      mips_pkg::op_lui: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.alu_op  = mips_pkg::alu_lui;
      end
      mips_pkg::op_lw: begin
        ctrl.reg_wr     = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.ext_signed = 1'b1;
        ctrl.mem_rd     = 1'b1;
        ctrl.alu_op     = mips_pkg::alu_add;
      end
      mips_pkg::op_sw: begin
        ctrl.alu_src    = 1'b1;
        ctrl.ext_signed = 1'b1;
        ctrl.mem_wr     = 1'b1;
        ctrl.alu_op     = mips_pkg::alu_add;
      end
      mips_pkg::op_beq: ctrl.branch_eq = 1'b1;
      mips_pkg::op_bne: ctrl.branch_ne = 1'b1;
      mips_pkg::op_j:   ctrl.jump = 1'b1;
      default:          ctrl = '0;
    endcase
  end

endmodule

//--- hdl/dm.sv
`timescale 1ns/1ps

module dm (
  input  logic            clk,
  input  logic            we,
  input  mips_pkg::word_t addr,
  input  mips_pkg::word_t wdata,
  output mips_pkg::word_t rdata
);

  mips_pkg::word_t mem [mips_pkg::dm_words];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr[$clog2(mips_pkg::dm_words)-1:0]] <= wdata;
    end
  end

  // read is combinational so writeback gets the word in the mem stage
  assign rdata = mem[addr[$clog2(mips_pkg::dm_words)-1:0]];

  a_wr_range: assert property (@(posedge clk) we |-> addr < mips_pkg::dm_words);

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  mips_pkg::reg_idx_t id_rs,
  input  mips_pkg::reg_idx_t id_rt,
  input  mips_pkg::ctrl_t    id_ctrl,
  input  mips_pkg::reg_idx_t ex_rs,
  input  mips_pkg::reg_idx_t ex_rt,
  input  mips_pkg::reg_idx_t ex_rw,
  input  logic               ex_reg_wr,
  input  logic               ex_mem_rd,
  input  mips_pkg::reg_idx_t mem_rw,
  input  logic               mem_reg_wr,
  input  logic               mem_mem_rd,
  input  mips_pkg::reg_idx_t wb_rw,
  input  logic               wb_reg_wr,
  output mips_pkg::fwd_t     fwd_a,
  output mips_pkg::fwd_t     fwd_b,
  output logic               br_fwd_a,
  output logic               br_fwd_b,
  output logic               stall
);

  logic id_branch;
  logic load_use;
  logic br_dep_ex;
  logic br_dep_mem;

  // true when a producer writes src and src is not r0
  function automatic logic hit(input mips_pkg::reg_idx_t rw, input logic wr,
                               input mips_pkg::reg_idx_t src);
    return wr && rw != '0 && rw == src;
  endfunction

  // mem holds the younger value and wins over wb
  assign fwd_a = hit(mem_rw, mem_reg_wr, ex_rs) ? mips_pkg::fwd_mem :
                 hit(wb_rw, wb_reg_wr, ex_rs)   ? mips_pkg::fwd_wb  : mips_pkg::fwd_none;
  assign fwd_b = hit(mem_rw, mem_reg_wr, ex_rt) ? mips_pkg::fwd_mem :
                 hit(wb_rw, wb_reg_wr, ex_rt)   ? mips_pkg::fwd_wb  : mips_pkg::fwd_none;

  // branch compare only takes alu results from mem
  assign br_fwd_a = hit(mem_rw, mem_reg_wr, id_rs) && !mem_mem_rd;
  assign br_fwd_b = hit(mem_rw, mem_reg_wr, id_rt) && !mem_mem_rd;

  assign id_branch = id_ctrl.branch_eq || id_ctrl.branch_ne;
  assign load_use  = ex_mem_rd && (hit(ex_rw, ex_reg_wr, id_rs) || hit(ex_rw, ex_reg_wr, id_rt));
  assign br_dep_ex = id_branch && (hit(ex_rw, ex_reg_wr, id_rs) || hit(ex_rw, ex_reg_wr, id_rt));
  assign br_dep_mem = id_branch && mem_mem_rd &&
                      (hit(mem_rw, mem_reg_wr, id_rs) || hit(mem_rw, mem_reg_wr, id_rt));
  assign stall = load_use || br_dep_ex || br_dep_mem;

  // worst case is a branch on a load that waits in ex and then in mem
  a_stall_len: assert property (@(posedge clk) disable iff (!rst_n)
    stall [*2] |=> !stall);

endmodule

//--- hdl/mips.sv
`timescale 1ns/1ps

module mips (
  input  logic               clk,
  input  logic               rst_n,
  output mips_pkg::pc_t      imem_addr,
  input  mips_pkg::word_t    imem_data,
  output logic               retire_valid,
  output mips_pkg::reg_idx_t retire_rw,
  output mips_pkg::word_t    retire_data
);

  mips_pkg::pc_t      pc;
  mips_pkg::pc_t      pc_plus1;
  mips_pkg::pc_t      pc_next;
  // if/id
  logic               if_valid;
  mips_pkg::word_t    if_instr;
  mips_pkg::pc_t      if_pc1;
  // decode
  mips_pkg::instr_t   id_instr;
  mips_pkg::ctrl_t    id_ctrl;
  mips_pkg::word_t    id_busa;
  mips_pkg::word_t    id_busb;
  mips_pkg::word_t    id_imm_ext;
  mips_pkg::reg_idx_t id_rw;
  mips_pkg::word_t    br_a;
  mips_pkg::word_t    br_b;
  mips_pkg::pc_t      br_target;
  mips_pkg::pc_t      j_target;
  logic               br_taken;
  logic               br_fwd_a;
  logic               br_fwd_b;
  logic               stall;
  mips_pkg::fwd_t     fwd_a;
  mips_pkg::fwd_t     fwd_b;
  // stage registers
  mips_pkg::id_ex_t   id_ex;
  mips_pkg::ex_mem_t  ex_mem;
  mips_pkg::mem_wb_t  mem_wb;
  // execute, memory, writeback
  mips_pkg::word_t    ex_a_fwd;
  mips_pkg::word_t    ex_b_fwd;
  mips_pkg::word_t    alu_a;
  mips_pkg::word_t    alu_b;
  mips_pkg::word_t    alu_y;
  mips_pkg::word_t    dm_rdata;
  mips_pkg::word_t    mem_result;
  logic               wb_we;

  function automatic mips_pkg::word_t fwd_mux(input mips_pkg::fwd_t sel,
      input mips_pkg::word_t rf_val, input mips_pkg::word_t mem_val,
      input mips_pkg::word_t wb_val);
    case (sel)
      mips_pkg::fwd_mem: return mem_val;
      mips_pkg::fwd_wb:  return wb_val;
      default:           return rf_val;
    endcase
  endfunction

  // fetch
  assign imem_addr = pc;
  assign pc_plus1  = pc + 30'd1;

  always_comb begin
    if (stall) begin
      pc_next = pc;
    end else if (id_ctrl.jump) begin
      pc_next = j_target;
    end else if (br_taken) begin
      pc_next = br_target;
    end else begin
      pc_next = pc_plus1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  // a taken transfer squashes the word fetched behind it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      if_valid <= 1'b0;
    end else if (!stall) begin
      if_valid <= !(id_ctrl.jump || br_taken);
      if_instr <= imem_data;
      if_pc1   <= pc_plus1;
    end
  end

  // decode, an empty slot reads as all zero
  assign id_instr = if_valid ? if_instr : '0;

  ctrl a_ctrl (.instr(id_instr), .ctrl(id_ctrl));

  rf a_rf (
    .clk (clk),          .we  (wb_we),          .rw  (mem_wb.rw), .busw(mem_wb.result),
    .ra  (id_instr.r.rs), .rb (id_instr.r.rt),  .busa(id_busa),   .busb(id_busb)
  );

  assign id_imm_ext = id_ctrl.ext_signed ? {{16{id_instr.i.imm[15]}}, id_instr.i.imm}
                                         : {16'b0, id_instr.i.imm};
  assign id_rw      = id_ctrl.reg_dst ? id_instr.r.rd : id_instr.r.rt;

  // branches resolve here against mem-forwarded operands
  assign br_a      = br_fwd_a ? ex_mem.alu_result : id_busa;
  assign br_b      = br_fwd_b ? ex_mem.alu_result : id_busb;
  assign br_taken  = (id_ctrl.branch_eq && br_a == br_b) || (id_ctrl.branch_ne && br_a != br_b);
  assign br_target = if_pc1 + {{14{id_instr.i.imm[15]}}, id_instr.i.imm};
  assign j_target  = {if_pc1[29:26], id_instr.j.target};

  hazard_unit a_hazard (
    .clk       (clk),                                    .rst_n     (rst_n),
    .id_rs     (id_instr.r.rs),                          .id_rt     (id_instr.r.rt),
    .id_ctrl   (id_ctrl),
    .ex_rs     (id_ex.rs),                               .ex_rt     (id_ex.rt),
    .ex_rw     (id_ex.rw),
    .ex_reg_wr (id_ex.valid && id_ex.ctrl.reg_wr),
    .ex_mem_rd (id_ex.valid && id_ex.ctrl.mem_rd),
    .mem_rw    (ex_mem.rw),
    .mem_reg_wr(ex_mem.valid && ex_mem.ctrl.reg_wr),
    .mem_mem_rd(ex_mem.valid && ex_mem.ctrl.mem_rd),
    .wb_rw     (mem_wb.rw),                              .wb_reg_wr (wb_we),
    .fwd_a     (fwd_a),                                  .fwd_b     (fwd_b),
    .br_fwd_a  (br_fwd_a),                               .br_fwd_b  (br_fwd_b),
    .stall     (stall)
  );

  // a stall leaves a bubble in execute
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.valid   <= if_valid && !stall;
      id_ex.ctrl    <= id_ctrl;
      id_ex.rs      <= id_instr.r.rs;
      id_ex.rt      <= id_instr.r.rt;
      id_ex.rw      <= id_rw;
      id_ex.busa    <= id_busa;
      id_ex.busb    <= id_busb;
      id_ex.imm_ext <= id_imm_ext;
      id_ex.shamt   <= id_instr.r.shamt;
    end
  end

  // execute
  assign ex_a_fwd = fwd_mux(fwd_a, id_ex.busa, ex_mem.alu_result, mem_wb.result);
  assign ex_b_fwd = fwd_mux(fwd_b, id_ex.busb, ex_mem.alu_result, mem_wb.result);
  assign alu_a    = (id_ex.ctrl.alu_op == mips_pkg::alu_sll) ? {27'b0, id_ex.shamt} : ex_a_fwd;
  assign alu_b    = id_ex.ctrl.alu_src ? id_ex.imm_ext : ex_b_fwd;

  alu a_alu (.a(alu_a), .b(alu_b), .op(id_ex.ctrl.alu_op), .y(alu_y));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.ctrl       <= id_ex.ctrl;
      ex_mem.rw         <= id_ex.rw;
      ex_mem.alu_result <= alu_y;
      ex_mem.store_data <= ex_b_fwd;
    end
  end

  // memory
  dm a_dm (
    .clk  (clk),                                  .we   (ex_mem.valid && ex_mem.ctrl.mem_wr),
    .addr (ex_mem.alu_result),                    .wdata(ex_mem.store_data),
    .rdata(dm_rdata)
  );

  assign mem_result = ex_mem.ctrl.mem_rd ? dm_rdata : ex_mem.alu_result;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb.valid <= 1'b0;
    end else begin
      mem_wb.valid  <= ex_mem.valid;
      mem_wb.reg_wr <= ex_mem.ctrl.reg_wr;
      mem_wb.rw     <= ex_mem.rw;
      mem_wb.result <= mem_result;
    end
  end

  // writeback and retire
  assign wb_we        = mem_wb.valid && mem_wb.reg_wr;
  assign retire_valid = wb_we && mem_wb.rw != '0;
  assign retire_rw    = mem_wb.rw;
  assign retire_data  = mem_wb.result;

endmodule

//--- hdl/mips_pkg.sv
package mips_pkg;

  typedef logic [31:0] word_t;
  // word address, the two byte bits are dropped
  typedef logic [29:0] pc_t;
  typedef logic [4:0]  reg_idx_t;

  localparam int dm_words = 1024;

  // opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_bne   = 6'h05;
  localparam logic [5:0] op_addiu = 6'h09;
  localparam logic [5:0] op_ori   = 6'h0d;
  localparam logic [5:0] op_lui   = 6'h0f;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  // r-type function codes
  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_slt  = 6'h2a;

  typedef struct packed {
    logic [5:0] op;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    logic [5:0]  op;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;
  } j_fmt_t;

  // one instruction word, three field layouts
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_sll,
    alu_lui
  } alu_op_t;

  typedef struct packed {
    logic    reg_wr;
    logic    reg_dst;
    logic    alu_src;
    logic    ext_signed;
    logic    mem_rd;
    logic    mem_wr;
    logic    branch_eq;
    logic    branch_ne;
    logic    jump;
    alu_op_t alu_op;
  } ctrl_t;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_mem,
    fwd_wb
  } fwd_t;

  typedef struct packed {
    logic       valid;
    ctrl_t      ctrl;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rw;
    word_t      busa;
    word_t      busb;
    word_t      imm_ext;
    logic [4:0] shamt;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    reg_idx_t rw;
    word_t    alu_result;
    word_t    store_data;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    logic     reg_wr;
    reg_idx_t rw;
    word_t    result;
  } mem_wb_t;

endpackage

//--- hdl/rf.sv
`timescale 1ns/1ps

module rf (
  input  logic               clk,
  input  logic               we,
  input  mips_pkg::reg_idx_t rw,
  input  mips_pkg::word_t    busw,
  input  mips_pkg::reg_idx_t ra,
  input  mips_pkg::reg_idx_t rb,
  output mips_pkg::word_t    busa,
  output mips_pkg::word_t    busb
);

  mips_pkg::word_t regs [32];

  always_ff @(posedge clk) begin
    if (we && rw != '0) begin
      regs[rw] <= busw;
    end
  end

  // writeback value seen by decode in the same cycle
  assign busa = (ra == '0) ? '0 : (we && rw == ra) ? busw : regs[ra];
  assign busb = (rb == '0) ? '0 : (we && rw == rb) ? busw : regs[rb];

endmodule

//--- run.sh
#!/bin/sh
# compile and run the mips testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mips -f build.f -o tb_mips
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_mips)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- tests/mips_trace.txt
# I <word address> <instruction word>, both hex
# W <register> <expected writeback value>, both hex, in retire order
I 00 24010005
I 01 342200f0
I 02 3c031234
I 03 00622021
I 04 00812823
I 05 00a23024
I 06 00c33825
I 07 2409fffd
I 08 0121402a
I 09 00085100
I 0a 24200007
I 0b 00015821
I 0c ac040008
I 0d ac090009
I 0e 8c0c0008
I 0f 01816821
I 10 102b0001
I 11 240e0bad
I 12 142b0001
I 13 240e0011
I 14 15c10001
I 15 240f0bad
I 16 11c10001
I 17 240f0022
I 18 8c100009
I 19 12090001
I 1a 24110bad
I 1b 0800001e
I 1c 24120bad
I 1d 24130bad
I 1e 0000a021
I 1f 0800001f
# alu ops and immediates, r0 write gives no entry
W 01 00000005
W 02 000000f5
W 03 12340000
W 04 123400f5
W 05 123400f0
W 06 000000f0
W 07 123400f0
W 09 fffffffd
W 08 00000001
W 0a 00000010
W 0b 00000005
# load and load-use
W 0c 123400f5
W 0d 123400fa
# branches, then load feeding a branch, then the jump target
W 0e 00000011
W 0f 00000022
W 10 fffffffd
W 14 00000000

//--- tests/tb_mips.sv
`timescale 1ns/1ps

module tb_mips;

  typedef struct packed {
    mips_pkg::reg_idx_t rw;
    mips_pkg::word_t    data;
  } wb_entry_t;

  logic               clk = 1'b0;
  logic               rst_n;
  mips_pkg::pc_t      imem_addr;
  mips_pkg::word_t    imem_data;
  logic               retire_valid;
  mips_pkg::reg_idx_t retire_rw;
  mips_pkg::word_t    retire_data;

  // program words by word address
  mips_pkg::word_t rom [mips_pkg::pc_t];
  wb_entry_t       expected [$];
  int              n_instr;
  int              cycles;
  int              limit;

  mips i_mips (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .retire_valid(retire_valid),
    .retire_rw   (retire_rw),
    .retire_data (retire_data)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_reg_idx(input string name, input mips_pkg::reg_idx_t exp,
                               input mips_pkg::reg_idx_t act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input mips_pkg::word_t exp,
                            input mips_pkg::word_t act);
    if (act !== exp) begin
      fail_run($sformatf("mismatch %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
  endtask

  // I lines fill the rom and W lines queue the expected writebacks
  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    string       tag;
    logic [31:0] f1;
    logic [31:0] f2;
    wb_entry_t   entry;
    fd = $fopen("tests/mips_trace.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the trace file tests/mips_trace.txt");
    end
    n_instr = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2) continue;
      tag = line.substr(0, 0);
      if (tag == "#") continue;
      n = $sscanf(line.substr(1, line.len() - 1), "%h %h", f1, f2);
      if (n != 2) begin
        fail_run($sformatf("trace line could not be parsed: %s", line));
      end else if (tag == "I") begin
        rom[f1[29:0]] = f2;
        n_instr++;
      end else if (tag == "W") begin
        entry.rw   = f1[4:0];
        entry.data = f2;
        expected.push_back(entry);
      end else begin
        fail_run($sformatf("trace line has an unknown tag: %s", line));
      end
    end
    $fclose(fd);
  endtask

  task automatic check_retire();
    wb_entry_t entry;
    if (expected.size() == 0) begin
      fail_run($sformatf("unexpected writeback to register %0d with data 0x%h",
                         retire_rw, retire_data));
    end else begin
      entry = expected.pop_front();
      check_reg_idx("retire_rw", entry.rw, retire_rw);
      check_word("retire_data", entry.data, retire_data);
    end
  endtask

  initial begin
    forever #20 clk = ~clk;
  end

  // retire outputs are steady at the falling edge
  always @(negedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      fail_run($sformatf("timeout: expected writebacks still pending after %0d cycles",
                         limit));
    end
    if (retire_valid) begin
      check_retire();
    end
    // fetch port answers the pc that moved at the last rising edge
    imem_data = rom.exists(imem_addr) ? rom[imem_addr] : '0;
  end

  initial begin
    rst_n     = 1'b0;
    imem_data = '0;
    cycles    = 0;
    limit     = 1000;
    load_trace();
    limit = 8 * n_instr + 50;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    while (expected.size() != 0) begin
      @(negedge clk);
    end
    // a few more cycles so a stray write behind the last one is caught
    repeat (5) @(negedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule
